// File: source/mips_ex_macros.svh
`ifndef MIPS_EX_MACROS_SVH
`define MIPS_EX_MACROS_SVH

`define NB_DATA     32
`define NB_REG_ADDR 5
`define MEM_DEPTH   64

`define OP_RTYPE    6'b000000
`define OP_ADDI     6'b001000
`define OP_SLTI     6'b001010
`define OP_ANDI     6'b001100
`define OP_ORI      6'b001101
`define OP_XORI     6'b001110
`define OP_LUI      6'b001111
`define OP_LW       6'b100011
`define OP_SW       6'b101011

`define FN_ADD      6'b100000
`define FN_SUB      6'b100010
`define FN_AND      6'b100100
`define FN_OR       6'b100101
`define FN_XOR      6'b100110
`define FN_SLT      6'b101010
`define FN_SLL      6'b000000
`define FN_SRL      6'b000010

`endif

// File: source/mips_ex_pkg.sv
`include "mips_ex_macros.svh"

package mips_ex_pkg;

    typedef logic [`NB_DATA-1:0]     word_t;
    typedef logic [`NB_REG_ADDR-1:0] reg_idx_t;
    typedef logic [5:0]              alu_op_t;
    typedef logic [4:0]              shamt_t;

    // how the execute stage builds its alu operation
    typedef enum logic [1:0] {
        LOAD_STORE = 2'b00,
        BRANCH     = 2'b01,
        R_TYPE     = 2'b10,
        I_TYPE     = 2'b11
    } alu_class_t;

    typedef enum logic [1:0] {
        FWD_NONE  = 2'b00,
        FWD_MEMWB = 2'b10,
        FWD_EXMEM = 2'b11
    } fwd_sel_t;

endpackage

// File: source/control_unit.sv
`include "mips_ex_macros.svh"

module control_unit import mips_ex_pkg::*; (
    input  word_t      i_instr,
    output reg_idx_t   o_rs,
    output reg_idx_t   o_rt,
    output reg_idx_t   o_rd,
    output alu_op_t    o_opcode,
    output alu_op_t    o_func,
    output shamt_t     o_shamt,
    output word_t      o_immediate,
    output logic       o_reg_dst,
    output logic       o_mem2reg,
    output logic       o_mem_read,
    output logic       o_mem_write,
    output logic       o_reg_write,
    output logic       o_immediate_flag,
    output alu_class_t o_alu_class
);

    logic [15:0] imm16;

    assign o_opcode = i_instr[31:26];
    assign o_rs     = i_instr[25:21];
    assign o_rt     = i_instr[20:16];
    assign o_rd     = i_instr[15:11];
    assign o_shamt  = i_instr[10:6];
    assign o_func   = i_instr[5:0];
    assign imm16    = i_instr[15:0];

    always_comb begin
        o_immediate      = {{(`NB_DATA-16){imm16[15]}}, imm16};
        o_reg_dst        = 1'b0;
        o_mem2reg        = 1'b0;
        o_mem_read       = 1'b0;
        o_mem_write      = 1'b0;
        o_reg_write      = 1'b0;
        o_immediate_flag = 1'b0;
        o_alu_class      = BRANCH;
        case (o_opcode)
            `OP_RTYPE: begin
                o_reg_dst   = 1'b1;
                o_reg_write = 1'b1;
                o_alu_class = R_TYPE;
            end
            `OP_ADDI, `OP_SLTI: begin
                o_reg_write      = 1'b1;
                o_immediate_flag = 1'b1;
                o_alu_class      = I_TYPE;
            end
            // logical immediates are zero extended
            `OP_ANDI, `OP_ORI, `OP_XORI: begin
                o_immediate      = word_t'(imm16);
                o_reg_write      = 1'b1;
                o_immediate_flag = 1'b1;
                o_alu_class      = I_TYPE;
            end
            `OP_LUI: begin
                o_immediate      = {imm16, {(`NB_DATA-16){1'b0}}};
                o_reg_write      = 1'b1;
                o_immediate_flag = 1'b1;
                o_alu_class      = I_TYPE;
            end
            `OP_LW: begin
                o_mem2reg        = 1'b1;
                o_mem_read       = 1'b1;
                o_reg_write      = 1'b1;
                o_immediate_flag = 1'b1;
                o_alu_class      = LOAD_STORE;
            end
            `OP_SW: begin
                o_mem_write      = 1'b1;
                o_immediate_flag = 1'b1;
                o_alu_class      = LOAD_STORE;
            end
            // unknown opcode runs as a nop
            default: begin
                o_alu_class = BRANCH;
            end
        endcase
    end

endmodule

// File: source/register_file.sv
`include "mips_ex_macros.svh"

module register_file import mips_ex_pkg::*; (
    input  logic     clk,
    input  logic     i_rst_n,
    input  reg_idx_t i_rd_addr_a,
    input  reg_idx_t i_rd_addr_b,
    input  logic     i_wr_en,
    input  reg_idx_t i_wr_addr,
    input  word_t    i_wr_data,
    output word_t    o_rd_data_a,
    output word_t    o_rd_data_b
);

    localparam int NUM_REGS = 2**`NB_REG_ADDR;

    word_t regs [NUM_REGS];

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wr_en && (i_wr_addr != '0)) begin
            regs[i_wr_addr] <= i_wr_data;
        end
    end

    // same-cycle write is visible to the decoding instruction
    assign o_rd_data_a = (i_rd_addr_a == '0) ? '0 :
                         (i_wr_en && (i_wr_addr == i_rd_addr_a)) ? i_wr_data :
                         regs[i_rd_addr_a];
    assign o_rd_data_b = (i_rd_addr_b == '0) ? '0 :
                         (i_wr_en && (i_wr_addr == i_rd_addr_b)) ? i_wr_data :
                         regs[i_rd_addr_b];

endmodule

// File: source/hazard_forward_unit.sv
module hazard_forward_unit import mips_ex_pkg::*; (
    input  reg_idx_t i_idex_rs,
    input  reg_idx_t i_idex_rt,
    input  reg_idx_t i_exmem_rd,
    input  logic     i_exmem_reg_write,
    input  logic     i_exmem_mem_read,
    input  reg_idx_t i_memwb_rd,
    input  logic     i_memwb_reg_write,
    input  reg_idx_t i_id_rs,
    input  reg_idx_t i_id_rt,
    input  reg_idx_t i_idex_rd,
    input  logic     i_idex_mem_read,
    output fwd_sel_t o_fw_a,
    output fwd_sel_t o_fw_b,
    output logic     o_stall
);

    logic exmem_fwd_ok;
    logic memwb_fwd_ok;

    // a load still in ex/mem only holds its address
    assign exmem_fwd_ok = i_exmem_reg_write && !i_exmem_mem_read && (i_exmem_rd != '0);
    assign memwb_fwd_ok = i_memwb_reg_write && (i_memwb_rd != '0);

    assign o_fw_a = (exmem_fwd_ok && (i_exmem_rd == i_idex_rs)) ? FWD_EXMEM :
                    (memwb_fwd_ok && (i_memwb_rd == i_idex_rs)) ? FWD_MEMWB :
                    FWD_NONE;
    assign o_fw_b = (exmem_fwd_ok && (i_exmem_rd == i_idex_rt)) ? FWD_EXMEM :
                    (memwb_fwd_ok && (i_memwb_rd == i_idex_rt)) ? FWD_MEMWB :
                    FWD_NONE;

    // load-use, hold the consumer one cycle
    assign o_stall = i_idex_mem_read && (i_idex_rd != '0) &&
                     ((i_idex_rd == i_id_rs) || (i_idex_rd == i_id_rt));

endmodule

// File: source/alu.sv
`include "mips_ex_macros.svh"

module alu import mips_ex_pkg::*; (
    input  alu_op_t i_op,
    input  word_t   i_dato_a,
    input  word_t   i_dato_b,
    input  shamt_t  i_shamt,
    output word_t   o_result
);

    always_comb begin
        case (i_op)
            `FN_ADD, `OP_ADDI: begin
                o_result = i_dato_a + i_dato_b;
            end
            `FN_SUB: begin
                o_result = i_dato_a - i_dato_b;
            end
            `FN_AND, `OP_ANDI: begin
                o_result = i_dato_a & i_dato_b;
            end
            `FN_OR, `OP_ORI: begin
                o_result = i_dato_a | i_dato_b;
            end
            `FN_XOR, `OP_XORI: begin
                o_result = i_dato_a ^ i_dato_b;
            end
            `FN_SLT, `OP_SLTI: begin
                o_result = word_t'($signed(i_dato_a) < $signed(i_dato_b));
            end
            `FN_SLL: begin
                o_result = i_dato_b << i_shamt;
            end
            `FN_SRL: begin
                o_result = i_dato_b >> i_shamt;
            end
            // immediate arrives already shifted up
            `OP_LUI: begin
                o_result = i_dato_b;
            end
            default: begin
                o_result = '0;
            end
        endcase
    end

endmodule

// File: source/instruction_execute.sv
`include "mips_ex_macros.svh"

module instruction_execute import mips_ex_pkg::*; (
    input  logic       clk,
    input  logic       i_rst_n,
    input  logic       i_halt,
    input  reg_idx_t   i_rs,
    input  reg_idx_t   i_rt,
    input  reg_idx_t   i_rd,
    input  word_t      i_reg_da,
    input  word_t      i_reg_db,
    input  word_t      i_immediate,
    input  alu_op_t    i_opcode,
    input  alu_op_t    i_func,
    input  shamt_t     i_shamt,
    input  logic       i_reg_dst,
    input  logic       i_mem2reg,
    input  logic       i_mem_read,
    input  logic       i_mem_write,
    input  logic       i_reg_write,
    input  logic       i_immediate_flag,
    input  alu_class_t i_alu_class,
    input  fwd_sel_t   i_fw_a,
    input  fwd_sel_t   i_fw_b,
    input  word_t      i_output_memwb,
    input  word_t      i_output_exmem,
    output logic       o_mem2reg,
    output logic       o_mem_read,
    output logic       o_mem_write,
    output logic       o_reg_write,
    output reg_idx_t   o_write_reg,
    output word_t      o_data4mem,
    output word_t      o_result
);

    localparam alu_op_t ALU_IDLE = 6'b111111;

    alu_op_t  alu_op;
    word_t    alu_dato_a;
    word_t    alu_dato_b;
    word_t    data4mem;
    word_t    alu_result;
    reg_idx_t write_reg;

    function automatic word_t pick_operand(
        input fwd_sel_t sel,
        input word_t    reg_val,
        input word_t    exmem_val,
        input word_t    memwb_val
    );
        case (sel)
            FWD_EXMEM: return exmem_val;
            FWD_MEMWB: return memwb_val;
            default:   return reg_val;
        endcase
    endfunction

    always_comb begin
        case (i_alu_class)
            LOAD_STORE: alu_op = `FN_ADD;
            R_TYPE:     alu_op = i_func;
            I_TYPE:     alu_op = i_opcode;
            default:    alu_op = ALU_IDLE;
        endcase
    end

    // r0 reads zero on every path
    assign alu_dato_a = (i_rs == '0) ? '0 :
                        pick_operand(i_fw_a, i_reg_da, i_output_exmem, i_output_memwb);
    assign data4mem   = (i_rt == '0) ? '0 :
                        pick_operand(i_fw_b, i_reg_db, i_output_exmem, i_output_memwb);
    // store data taken before the immediate swap
    assign alu_dato_b = i_immediate_flag ? i_immediate : data4mem;
    assign write_reg  = i_reg_dst ? i_rd : i_rt;

    alu alu_i (
        .i_op     (alu_op),
        .i_dato_a (alu_dato_a),
        .i_dato_b (alu_dato_b),
        .i_shamt  (i_shamt),
        .o_result (alu_result)
    );

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_mem2reg   <= 1'b0;
            o_mem_read  <= 1'b0;
            o_mem_write <= 1'b0;
            o_reg_write <= 1'b0;
        end else if (!i_halt) begin
            o_mem2reg   <= i_mem2reg;
            o_mem_read  <= i_mem_read;
            o_mem_write <= i_mem_write;
            o_reg_write <= i_reg_write;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_halt) begin
            o_write_reg <= write_reg;
            o_data4mem  <= data4mem;
            o_result    <= alu_result;
        end
    end

endmodule

// File: source/memory_writeback.sv
`include "mips_ex_macros.svh"

module memory_writeback import mips_ex_pkg::*; (
    input  logic     clk,
    input  logic     i_rst_n,
    input  logic     i_halt,
    input  logic     i_mem2reg,
    input  logic     i_mem_read,
    input  logic     i_mem_write,
    input  logic     i_reg_write,
    input  reg_idx_t i_write_reg,
    input  word_t    i_data4mem,
    input  word_t    i_result,
    output logic     o_wb_en,
    output reg_idx_t o_wb_reg,
    output word_t    o_wb_data
);

    localparam int NB_MEM_ADDR = $clog2(`MEM_DEPTH);

    word_t                  mem [`MEM_DEPTH];
    logic [NB_MEM_ADDR-1:0] mem_addr;
    word_t                  rd_data;
    logic                   wb_en_q;

    // word addressed, byte offset dropped
    assign mem_addr = i_result[NB_MEM_ADDR+1:2];
    assign rd_data  = i_mem_read ? mem[mem_addr] : '0;

    always_ff @(posedge clk) begin
        if (!i_halt && i_mem_write) begin
            mem[mem_addr] <= i_data4mem;
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wb_en_q <= 1'b0;
        end else if (!i_halt) begin
            wb_en_q <= i_reg_write && (i_write_reg != '0);
        end
    end

    always_ff @(posedge clk) begin
        if (!i_halt) begin
            o_wb_reg  <= i_write_reg;
            o_wb_data <= i_mem2reg ? rd_data : i_result;
        end
    end

    // retires once, not on every held cycle
    assign o_wb_en = wb_en_q && !i_halt;

endmodule

// File: source/execute_subsystem_top.sv
module execute_subsystem_top import mips_ex_pkg::*; (
    input  logic     clk,
    input  logic     i_rst_n,
    input  logic     i_halt,
    input  word_t    i_instr,
    input  logic     i_instr_valid,
    output logic     o_instr_ready,
    output logic     o_wb_valid,
    output reg_idx_t o_wb_reg,
    output word_t    o_wb_data
);

    reg_idx_t   id_rs, id_rt, id_rd;
    alu_op_t    id_opcode, id_func;
    shamt_t     id_shamt;
    word_t      id_immediate, id_reg_da, id_reg_db;
    logic       id_reg_dst, id_mem2reg, id_mem_read, id_mem_write;
    logic       id_reg_write, id_immediate_flag;
    alu_class_t id_alu_class;

    reg_idx_t   idex_rs, idex_rt, idex_rd, idex_dst;
    alu_op_t    idex_opcode, idex_func;
    shamt_t     idex_shamt;
    word_t      idex_immediate, idex_reg_da, idex_reg_db;
    logic       idex_reg_dst, idex_mem2reg, idex_mem_read, idex_mem_write;
    logic       idex_reg_write, idex_immediate_flag;
    alu_class_t idex_alu_class;

    logic       exmem_mem2reg, exmem_mem_read, exmem_mem_write, exmem_reg_write;
    reg_idx_t   exmem_write_reg;
    word_t      exmem_data4mem, exmem_result;

    fwd_sel_t   fw_a, fw_b;
    logic       stall;
    logic       accept;

    assign o_instr_ready = !i_halt && !stall;
    assign accept        = i_instr_valid && o_instr_ready;
    assign idex_dst      = idex_reg_dst ? idex_rd : idex_rt;

    control_unit control_unit_i (
        .i_instr          (i_instr),
        .o_rs             (id_rs),
        .o_rt             (id_rt),
        .o_rd             (id_rd),
        .o_opcode         (id_opcode),
        .o_func           (id_func),
        .o_shamt          (id_shamt),
        .o_immediate      (id_immediate),
        .o_reg_dst        (id_reg_dst),
        .o_mem2reg        (id_mem2reg),
        .o_mem_read       (id_mem_read),
        .o_mem_write      (id_mem_write),
        .o_reg_write      (id_reg_write),
        .o_immediate_flag (id_immediate_flag),
        .o_alu_class      (id_alu_class)
    );

    register_file register_file_i (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_rd_addr_a (id_rs),
        .i_rd_addr_b (id_rt),
        .i_wr_en     (o_wb_valid),
        .i_wr_addr   (o_wb_reg),
        .i_wr_data   (o_wb_data),
        .o_rd_data_a (id_reg_da),
        .o_rd_data_b (id_reg_db)
    );

    hazard_forward_unit hazard_forward_unit_i (
        .i_idex_rs         (idex_rs),
        .i_idex_rt         (idex_rt),
        .i_exmem_rd        (exmem_write_reg),
        .i_exmem_reg_write (exmem_reg_write),
        .i_exmem_mem_read  (exmem_mem_read),
        .i_memwb_rd        (o_wb_reg),
        .i_memwb_reg_write (o_wb_valid),
        .i_id_rs           (id_rs),
        .i_id_rt           (id_rt),
        .i_idex_rd         (idex_dst),
        .i_idex_mem_read   (idex_mem_read),
        .o_fw_a            (fw_a),
        .o_fw_b            (fw_b),
        .o_stall           (stall)
    );

    // id/ex, a bubble goes in when no word is accepted
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            idex_mem2reg   <= 1'b0;
            idex_mem_read  <= 1'b0;
            idex_mem_write <= 1'b0;
            idex_reg_write <= 1'b0;
            idex_alu_class <= BRANCH;
        end else if (!i_halt) begin
            idex_mem2reg   <= accept && id_mem2reg;
            idex_mem_read  <= accept && id_mem_read;
            idex_mem_write <= accept && id_mem_write;
            idex_reg_write <= accept && id_reg_write;
            idex_alu_class <= accept ? id_alu_class : BRANCH;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_halt) begin
            idex_rs             <= id_rs;
            idex_rt             <= id_rt;
            idex_rd             <= id_rd;
            idex_opcode         <= id_opcode;
            idex_func           <= id_func;
            idex_shamt          <= id_shamt;
            idex_immediate      <= id_immediate;
            idex_reg_da         <= id_reg_da;
            idex_reg_db         <= id_reg_db;
            idex_reg_dst        <= id_reg_dst;
            idex_immediate_flag <= id_immediate_flag;
        end
    end

    instruction_execute instruction_execute_i (
        .clk              (clk),
        .i_rst_n          (i_rst_n),
        .i_halt           (i_halt),
        .i_rs             (idex_rs),
        .i_rt             (idex_rt),
        .i_rd             (idex_rd),
        .i_reg_da         (idex_reg_da),
        .i_reg_db         (idex_reg_db),
        .i_immediate      (idex_immediate),
        .i_opcode         (idex_opcode),
        .i_func           (idex_func),
        .i_shamt          (idex_shamt),
        .i_reg_dst        (idex_reg_dst),
        .i_mem2reg        (idex_mem2reg),
        .i_mem_read       (idex_mem_read),
        .i_mem_write      (idex_mem_write),
        .i_reg_write      (idex_reg_write),
        .i_immediate_flag (idex_immediate_flag),
        .i_alu_class      (idex_alu_class),
        .i_fw_a           (fw_a),
        .i_fw_b           (fw_b),
        .i_output_memwb   (o_wb_data),
        .i_output_exmem   (exmem_result),
        .o_mem2reg        (exmem_mem2reg),
        .o_mem_read       (exmem_mem_read),
        .o_mem_write      (exmem_mem_write),
        .o_reg_write      (exmem_reg_write),
        .o_write_reg      (exmem_write_reg),
        .o_data4mem       (exmem_data4mem),
        .o_result         (exmem_result)
    );

    memory_writeback memory_writeback_i (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_halt      (i_halt),
        .i_mem2reg   (exmem_mem2reg),
        .i_mem_read  (exmem_mem_read),
        .i_mem_write (exmem_mem_write),
        .i_reg_write (exmem_reg_write),
        .i_write_reg (exmem_write_reg),
        .i_data4mem  (exmem_data4mem),
        .i_result    (exmem_result),
        .o_wb_en     (o_wb_valid),
        .o_wb_reg    (o_wb_reg),
        .o_wb_data   (o_wb_data)
    );

endmodule

// File: bench/execute_subsystem_tb.sv
`include "mips_ex_macros.svh"

module execute_subsystem_tb import mips_ex_pkg::*; ();

    localparam int MEM_AW        = $clog2(`MEM_DEPTH);
    localparam int READY_TIMEOUT = 100;
    localparam int DRAIN_TIMEOUT = 200;
    localparam int RANDOM_COUNT  = 300;

    logic     clk;
    logic     i_rst_n;
    logic     i_halt = 1'b0;
    word_t    i_instr;
    logic     i_instr_valid;
    logic     o_instr_ready;
    logic     o_wb_valid;
    reg_idx_t o_wb_reg;
    word_t    o_wb_data;

    word_t    model_regs [2**`NB_REG_ADDR];
    word_t    model_mem [`MEM_DEPTH];
    reg_idx_t exp_reg_q [$];
    word_t    exp_data_q [$];
    int       exp_stamp_q [$];

    int       run_cycles;
    int       last_waits;
    logic     halt_en = 1'b0;
    int       halt_left = 0;
    reg_idx_t exp_reg;
    word_t    exp_data;
    int       exp_stamp;

    int data_errs    = 0;
    int latency_errs = 0;
    int extra_errs   = 0;
    int ready_errs   = 0;
    int timeout_errs = 0;

    alu_op_t rtype_fns [8] = '{`FN_ADD, `FN_SUB, `FN_AND, `FN_OR,
                               `FN_XOR, `FN_SLT, `FN_SLL, `FN_SRL};
    alu_op_t itype_ops [6] = '{`OP_ADDI, `OP_SLTI, `OP_ANDI, `OP_ORI, `OP_XORI, `OP_LUI};

    execute_subsystem_top dut_i (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_halt        (i_halt),
        .i_instr       (i_instr),
        .i_instr_valid (i_instr_valid),
        .o_instr_ready (o_instr_ready),
        .o_wb_valid    (o_wb_valid),
        .o_wb_reg      (o_wb_reg),
        .o_wb_data     (o_wb_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // counts edges where the pipeline moves
    always @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            run_cycles <= 0;
        end else if (!i_halt) begin
            run_cycles <= run_cycles + 1;
        end
    end

    // random halt bursts of one to four cycles
    always @(posedge clk) begin
        if (!halt_en) begin
            i_halt <= 1'b0;
        end else if (halt_left != 0) begin
            halt_left <= halt_left - 1;
            i_halt    <= 1'b1;
        end else if ($urandom_range(0, 9) == 0) begin
            halt_left <= $urandom_range(0, 3);
            i_halt    <= 1'b1;
        end else begin
            i_halt <= 1'b0;
        end
    end

    always @(posedge clk) begin
        if (i_rst_n && o_wb_valid) begin
            assert (exp_reg_q.size() != 0) else begin
                extra_errs++;
                $display("writeback to register %0d arrived with nothing expected", o_wb_reg);
            end
            if (exp_reg_q.size() != 0) begin
                exp_reg   = exp_reg_q.pop_front();
                exp_data  = exp_data_q.pop_front();
                exp_stamp = exp_stamp_q.pop_front();
                assert (o_wb_reg == exp_reg) else begin
                    data_errs++;
                    $display("Fail o_wb_reg: got %h expected %h", o_wb_reg, exp_reg);
                end
                assert (o_wb_data == exp_data) else begin
                    data_errs++;
                    $display("Fail o_wb_data: got %h expected %h", o_wb_data, exp_data);
                end
                assert (run_cycles - exp_stamp == 3) else begin
                    latency_errs++;
                    $display("Fail o_wb_valid latency: got %h expected %h",
                             run_cycles - exp_stamp, 3);
                end
            end
        end
    end

    function automatic word_t rtype_word(input alu_op_t fn, input reg_idx_t rd,
                                         input reg_idx_t rs, input reg_idx_t rt,
                                         input shamt_t sh);
        return {`OP_RTYPE, rs, rt, rd, sh, fn};
    endfunction

    function automatic word_t itype_word(input alu_op_t op, input reg_idx_t rt,
                                         input reg_idx_t rs, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // architectural result of one instruction in program order
    function automatic bit model_exec(input word_t instr, output reg_idx_t dst,
                                      output word_t res);
        word_t a;
        word_t b;
        word_t simm;
        word_t zimm;
        word_t addr;
        bit    wr;
        a    = model_regs[instr[25:21]];
        b    = model_regs[instr[20:16]];
        simm = {{16{instr[15]}}, instr[15:0]};
        zimm = {16'h0000, instr[15:0]};
        addr = a + simm;
        wr   = 1'b1;
        dst  = instr[20:16];
        res  = '0;
        case (instr[31:26])
            `OP_RTYPE: begin
                dst = instr[15:11];
                case (instr[5:0])
                    `FN_ADD: res = a + b;
                    `FN_SUB: res = a - b;
                    `FN_AND: res = a & b;
                    `FN_OR:  res = a | b;
                    `FN_XOR: res = a ^ b;
                    `FN_SLT: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    `FN_SLL: res = b << instr[10:6];
                    `FN_SRL: res = b >> instr[10:6];
                    default: res = '0;
                endcase
            end
            `OP_ADDI: res = a + simm;
            `OP_SLTI: res = ($signed(a) < $signed(simm)) ? 32'd1 : 32'd0;
            `OP_ANDI: res = a & zimm;
            `OP_ORI:  res = a | zimm;
            `OP_XORI: res = a ^ zimm;
            `OP_LUI:  res = {instr[15:0], 16'h0000};
            `OP_LW:   res = model_mem[addr[MEM_AW+1:2]];
            `OP_SW: begin
                model_mem[addr[MEM_AW+1:2]] = b;
                wr = 1'b0;
            end
            default: wr = 1'b0;
        endcase
        if (wr && (dst != '0)) begin
            model_regs[dst] = res;
        end
        return wr && (dst != '0);
    endfunction

    // registers 0..7 only so neighbours collide often
    function automatic word_t random_instr();
        reg_idx_t    rs;
        reg_idx_t    rt;
        reg_idx_t    rd;
        logic [15:0] imm;
        int          kind;
        rs   = reg_idx_t'($urandom_range(0, 7));
        rt   = reg_idx_t'($urandom_range(0, 7));
        rd   = reg_idx_t'($urandom_range(0, 7));
        imm  = 16'($urandom);
        kind = $urandom_range(0, 15);
        if (kind < 8) begin
            return rtype_word(rtype_fns[kind], rd, rs, rt, shamt_t'($urandom_range(0, 31)));
        end else if (kind < 14) begin
            return itype_word(itype_ops[kind-8], rt, rs, imm);
        end else if (kind == 14) begin
            return itype_word(`OP_LW, rt, rs, imm);
        end else begin
            return itype_word(`OP_SW, rt, rs, imm);
        end
    endfunction

    task automatic issue_instr(input word_t w);
        reg_idx_t dst;
        word_t    res;
        i_instr       <= w;
        i_instr_valid <= 1'b1;
        last_waits = 0;
        @(posedge clk);
        while (!o_instr_ready && last_waits < READY_TIMEOUT) begin
            last_waits++;
            @(posedge clk);
        end
        if (o_instr_ready) begin
            if (model_exec(w, dst, res)) begin
                exp_reg_q.push_back(dst);
                exp_data_q.push_back(res);
                exp_stamp_q.push_back(run_cycles);
            end
        end else begin
            timeout_errs++;
            $display("timed out waiting for the instruction port to accept %h", w);
        end
    endtask

    task automatic idle_cycles(input int n);
        i_instr_valid <= 1'b0;
        repeat (n) @(posedge clk);
    endtask

    task automatic load_reg(input reg_idx_t r, input word_t v);
        issue_instr(itype_word(`OP_LUI, r, 5'd0, v[31:16]));
        issue_instr(itype_word(`OP_ORI, r, r, v[15:0]));
    endtask

    initial begin
        logic [15:0] fill;
        int          cnt;
        int          total;
        void'($urandom(40785));
        i_rst_n       = 1'b0;
        i_instr       = '0;
        i_instr_valid = 1'b0;
        for (int i = 0; i < 2**`NB_REG_ADDR; i++) begin
            model_regs[i] = '0;
        end
        for (int i = 0; i < `MEM_DEPTH; i++) begin
            model_mem[i] = '0;
        end
        repeat (8) @(posedge clk);
        i_rst_n <= 1'b1;
        @(posedge clk);

        // fill all of data memory with store data forwarded from ex/mem
        for (int i = 0; i < `MEM_DEPTH; i++) begin
            fill = 16'h9c5a ^ 16'(i * 32'h0301);
            issue_instr(itype_word(`OP_ORI, 5'd1, 5'd0, fill));
            issue_instr(itype_word(`OP_SW, 5'd1, 5'd0, 16'(i * 4)));
        end
        idle_cycles(4);

        // every operation in isolation
        for (int k = 0; k < 8; k++) begin
            load_reg(5'd1, $urandom);
            load_reg(5'd2, $urandom);
            idle_cycles(4);
            issue_instr(rtype_word(rtype_fns[k], 5'd3, 5'd1, 5'd2,
                                   shamt_t'($urandom_range(0, 31))));
            idle_cycles(4);
        end
        for (int k = 0; k < 6; k++) begin
            load_reg(5'd1, $urandom);
            idle_cycles(4);
            issue_instr(itype_word(itype_ops[k], 5'd4, 5'd1, 16'($urandom)));
            idle_cycles(4);
        end
        issue_instr(rtype_word(`FN_ADD, 5'd0, 5'd1, 5'd2, 5'd0));
        idle_cycles(4);
        issue_instr(itype_word(`OP_ORI, 5'd0, 5'd1, 16'h1234));
        idle_cycles(4);

        // dependent chain with no gaps
        load_reg(5'd1, $urandom);
        load_reg(5'd2, $urandom);
        issue_instr(rtype_word(`FN_ADD, 5'd3, 5'd1, 5'd2, 5'd0));
        issue_instr(rtype_word(`FN_SUB, 5'd4, 5'd3, 5'd1, 5'd0));
        issue_instr(rtype_word(`FN_XOR, 5'd5, 5'd4, 5'd3, 5'd0));
        issue_instr(rtype_word(`FN_SLL, 5'd6, 5'd0, 5'd5, 5'd7));
        issue_instr(itype_word(`OP_ADDI, 5'd7, 5'd6, 16'hff80));
        issue_instr(rtype_word(`FN_OR, 5'd3, 5'd7, 5'd5, 5'd0));
        issue_instr(rtype_word(`FN_SLT, 5'd4, 5'd3, 5'd7, 5'd0));
        idle_cycles(4);

        // store, reload, then load-use
        load_reg(5'd1, $urandom);
        idle_cycles(4);
        issue_instr(itype_word(`OP_SW, 5'd1, 5'd0, 16'h0048));
        idle_cycles(4);
        issue_instr(itype_word(`OP_LW, 5'd6, 5'd0, 16'h0048));
        idle_cycles(4);
        issue_instr(itype_word(`OP_LW, 5'd7, 5'd0, 16'h0048));
        issue_instr(rtype_word(`FN_ADD, 5'd8, 5'd7, 5'd1, 5'd0));
        assert (last_waits == 1) else begin
            ready_errs++;
            $display("Fail o_instr_ready low cycles: got %h expected %h", last_waits, 1);
        end
        idle_cycles(4);
        issue_instr(itype_word(`OP_LW, 5'd9, 5'd0, 16'h0010));
        issue_instr(itype_word(`OP_SW, 5'd9, 5'd0, 16'h004c));
        idle_cycles(4);
        issue_instr(itype_word(`OP_LW, 5'd10, 5'd0, 16'h004c));
        idle_cycles(4);

        halt_en <= 1'b1;
        for (int k = 0; k < RANDOM_COUNT; k++) begin
            if ($urandom_range(0, 3) == 0) begin
                idle_cycles($urandom_range(1, 3));
            end
            issue_instr(random_instr());
        end
        halt_en       <= 1'b0;
        i_instr_valid <= 1'b0;

        cnt = 0;
        while (exp_reg_q.size() != 0 && cnt < DRAIN_TIMEOUT) begin
            @(posedge clk);
            cnt++;
        end
        if (exp_reg_q.size() != 0) begin
            timeout_errs++;
            $display("timed out waiting for the pipeline to drain");
        end
        repeat (10) @(posedge clk);

        total = data_errs + latency_errs + extra_errs + ready_errs + timeout_errs
                + exp_reg_q.size();
        $display("errors: data %0d, latency %0d, extra writebacks %0d, ",
                 data_errs, latency_errs, extra_errs,
                 "ready %0d, timeouts %0d, left %0d",
                 ready_errs, timeout_errs, exp_reg_q.size());
        if (total == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: build.f
+incdir+source
source/mips_ex_pkg.sv
source/control_unit.sv
source/register_file.sv
source/hazard_forward_unit.sv
source/alu.sv
source/instruction_execute.sv
source/memory_writeback.sv
source/execute_subsystem_top.sv
bench/execute_subsystem_tb.sv
